// File: Makefile
# Verilator lint and simulation of the MPU testbench

VERILATOR ?= verilator
TOP       ?= mpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 32'h98c333b7
VFLAGS    ?= --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) "-GSEED=$(SEED)" \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG) && echo "PASS: $(LOG)" || \
		(echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/mpu_defs.svh
////////////////////////////////////////////////////////////////////////////
// MPU configuration constants
// Address width, region table size, bus credits and debug window
////////////////////////////////////////////////////////////////////////////

`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// Byte address width of core and bus requests
`define MPU_ADDR_W 32

// Number of entries in the fixed PMA region table
`define MPU_NUM_REGIONS 4

// Width of a region index into the table
`define MPU_IDX_W 2

// Credits the bus hands out at reset
`define MPU_BUS_CREDITS 2

// Debug module window, inside the catch-all main region
`define MPU_DM_START 32'h1A11_0000
// Last byte inside the window
`define MPU_DM_END 32'h1A11_3FFF

`endif

// File: common/mpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MPU transaction types
// Core request, bus request, core response and controller state
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mpu_pkg;

  typedef logic [3:0] txn_id_t;

  // Credit and outstanding transaction counts
  typedef logic [3:0] txn_cnt_t;

  typedef struct packed {
    pma_pkg::addr_t addr;
    logic           write;
    logic           fetch;
    logic           misaligned;
    logic           atomic;
    logic           pushpop;
    logic           debug;
    txn_id_t        id;
  } core_req_t;

  typedef struct packed {
    pma_pkg::addr_t addr;
    logic           write;
    logic           bufferable;
    logic           cacheable;
    txn_id_t        id;
  } bus_req_t;

  typedef struct packed {
    txn_id_t id;
    logic    err;
  } core_resp_t;

  // Error response sequencing
  typedef enum logic [1:0] {
    MPU_IDLE,
    MPU_DRAIN,
    MPU_ERR_RESP
  } mpu_state_e;

endpackage

`default_nettype wire

// File: common/pma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// PMA region attributes
// Region bound and attribute types plus the fixed region table
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`include "mpu_defs.svh"

package pma_pkg;

  typedef logic [`MPU_ADDR_W-1:0] addr_t;
  typedef logic [`MPU_ADDR_W-3:0] word_addr_t;
  typedef logic [`MPU_IDX_W-1:0]  region_idx_t;

  // High bound is exclusive
  typedef struct packed {
    word_addr_t word_addr_low;
    word_addr_t word_addr_high;
    logic       main;
    logic       bufferable;
    logic       cacheable;
    logic       atomic;
  } pma_cfg_t;

  // Regions overlap on purpose, the lowest index takes priority
  localparam pma_cfg_t PMA_REGIONS [`MPU_NUM_REGIONS] = '{
    // 0x0000_0000 .. 0x0000_0FFF  main RAM
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_0400,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1},
    // 0x0000_0800 .. 0x0000_FFFF  buffered scratch
    '{word_addr_low: 30'h0000_0200, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b1},
    // 0x1000_0000 .. 0x1000_3FFF  peripheral IO
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_1000,
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // 0x0000_0000 .. 0x1FFF_FFFF  catch-all main
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0800_0000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b0}
  };

  localparam pma_cfg_t PMA_DEFAULT = '{main: 1'b1, default: '0};

  // Debug module accesses in debug mode
  localparam pma_cfg_t PMA_DEBUG = '{main: 1'b1, default: '0};

endpackage

`default_nettype wire

// File: filelist.f
+incdir+common
common/pma_pkg.sv
common/mpu_pkg.sv
src/mpu/pma_region_decode.sv
src/mpu/pma_attr_execute.sv
src/mpu/mpu_result.sv
src/mpu/mpu_top.sv
tb/mpu_assert.sv
tb/mpu_checker.sv
tb/mpu_tb.sv

// File: src/mpu/mpu_result.sv
////////////////////////////////////////////////////////////////////////////
// MPU result stage
// Bus credits, outstanding count, error response FSM and core response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpu_result (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              ex_valid_i,
  input  wire mpu_pkg::bus_req_t ex_bus_req_i,
  input  wire logic              ex_err_i,
  input  wire logic              bus_credit_i,
  input  wire logic              bus_resp_valid_i,
  input  wire logic              bus_resp_err_i,
  input  wire mpu_pkg::txn_id_t  bus_resp_id_i,
  output logic                   bus_req_valid_o,
  output mpu_pkg::bus_req_t      bus_req_o,
  output logic                   core_resp_valid_o,
  output mpu_pkg::core_resp_t    core_resp_o,
  output logic                   stall_o,
  output logic                   block_core_o
);
  import mpu_pkg::*;

  mpu_state_e state_q;
  mpu_state_e state_d;
  txn_cnt_t   credit_q;
  txn_cnt_t   outstanding_q;
  logic       issue;
  logic       wait_credit;
  logic       err_pending;
  logic       err_resp;

  assign err_pending = ex_valid_i && ex_err_i;
  assign issue       = ex_valid_i && !ex_err_i && (credit_q != '0);
  assign wait_credit = ex_valid_i && !ex_err_i && (credit_q == '0);
  assign err_resp    = (state_q == MPU_ERR_RESP);

  assign bus_req_valid_o = issue;
  assign bus_req_o       = ex_bus_req_i;

  // The refused request sits in execute until its response is taken
  assign stall_o      = wait_credit || (err_pending && !err_resp);
  assign block_core_o = (state_q != MPU_IDLE);

  //////////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q      <= txn_cnt_t'(`MPU_BUS_CREDITS);
      outstanding_q <= '0;
    end else begin
      credit_q      <= credit_q + txn_cnt_t'(bus_credit_i) - txn_cnt_t'(issue);
      outstanding_q <= outstanding_q + txn_cnt_t'(issue) - txn_cnt_t'(bus_resp_valid_i);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Error response FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (err_pending) begin
          state_d = MPU_DRAIN;
        end
      end
      // Wait for every earlier bus transaction to answer
      MPU_DRAIN: begin
        if (outstanding_q == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: state_d = MPU_IDLE;
      default:      state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Core response
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_resp_valid_o <= 1'b0;
    end else begin
      core_resp_valid_o <= err_resp || bus_resp_valid_i;
    end
  end

  // Nothing is outstanding in MPU_ERR_RESP, so the two sources never meet
  always_ff @(posedge clk) begin
    if (err_resp) begin
      core_resp_o.id  <= ex_bus_req_i.id;
      core_resp_o.err <= 1'b1;
    end else if (bus_resp_valid_i) begin
      core_resp_o.id  <= bus_resp_id_i;
      core_resp_o.err <= bus_resp_err_i;
    end
  end

endmodule

`default_nettype wire

// File: src/mpu/mpu_top.sv
////////////////////////////////////////////////////////////////////////////
// MPU top level
// Decode, attribute and result stages between core port and bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mpu_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // Core side
  input  wire logic               core_req_valid_i,
  output logic                    core_req_ready_o,
  input  wire mpu_pkg::core_req_t core_req_i,
  output logic                    core_resp_valid_o,
  output mpu_pkg::core_resp_t     core_resp_o,
  // Bus side
  output logic                    bus_req_valid_o,
  output mpu_pkg::bus_req_t       bus_req_o,
  input  wire logic               bus_credit_i,
  input  wire logic               bus_resp_valid_i,
  input  wire logic               bus_resp_err_i,
  input  wire mpu_pkg::txn_id_t   bus_resp_id_i
);
  import pma_pkg::*;
  import mpu_pkg::*;

  logic      stall;
  logic      block_core;
  logic      dec_valid;
  core_req_t dec_req;
  pma_cfg_t  dec_cfg;
  logic      ex_valid;
  bus_req_t  ex_bus_req;
  logic      ex_err;

  assign core_req_ready_o = !stall && !block_core;

  pma_region_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (core_req_valid_i && core_req_ready_o),
    .req_i       (core_req_i),
    .stall_i     (stall),
    .dec_valid_o (dec_valid),
    .dec_req_o   (dec_req),
    .dec_cfg_o   (dec_cfg)
  );

  pma_attr_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid_i  (dec_valid),
    .dec_req_i    (dec_req),
    .dec_cfg_i    (dec_cfg),
    .stall_i      (stall),
    .ex_valid_o   (ex_valid),
    .ex_bus_req_o (ex_bus_req),
    .ex_err_o     (ex_err)
  );

  mpu_result u_result (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid_i        (ex_valid),
    .ex_bus_req_i      (ex_bus_req),
    .ex_err_i          (ex_err),
    .bus_credit_i      (bus_credit_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_err_i    (bus_resp_err_i),
    .bus_resp_id_i     (bus_resp_id_i),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .stall_o           (stall),
    .block_core_o      (block_core)
  );

endmodule

`default_nettype wire

// File: src/mpu/pma_attr_execute.sv
////////////////////////////////////////////////////////////////////////////
// PMA attribute stage
// Applies the access rules and builds the bus request attributes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_attr_execute (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               dec_valid_i,
  input  wire mpu_pkg::core_req_t dec_req_i,
  input  wire pma_pkg::pma_cfg_t  dec_cfg_i,
  input  wire logic               stall_i,
  output logic                    ex_valid_o,
  output mpu_pkg::bus_req_t       ex_bus_req_o,
  output logic                    ex_err_o
);
  import mpu_pkg::*;

  logic     region_err;
  logic     atomic_err;
  logic     err;
  bus_req_t bus_req;

  // Fetch, misaligned and push/pop all need main memory
  assign region_err = (dec_req_i.fetch || dec_req_i.misaligned || dec_req_i.pushpop) &&
                      !dec_cfg_i.main;

  // Atomics need region support and natural alignment
  assign atomic_err = dec_req_i.atomic && (!dec_cfg_i.atomic || dec_req_i.misaligned);

  assign err = region_err || atomic_err;

  always_comb begin
    bus_req.addr       = dec_req_i.addr;
    bus_req.write      = dec_req_i.write;
    bus_req.bufferable = dec_req_i.write && !dec_req_i.atomic && dec_cfg_i.bufferable;
    bus_req.cacheable  = dec_cfg_i.cacheable;
    bus_req.id         = dec_req_i.id;
  end

  //////////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o <= 1'b0;
    end else if (!stall_i) begin
      ex_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i && dec_valid_i) begin
      ex_bus_req_o <= bus_req;
      ex_err_o     <= err;
    end
  end

endmodule

`default_nettype wire

// File: src/mpu/pma_region_decode.sv
////////////////////////////////////////////////////////////////////////////
// PMA region decode stage
// Finds the lowest matching region and applies the debug override
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module pma_region_decode (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               req_valid_i,
  input  wire mpu_pkg::core_req_t req_i,
  input  wire logic               stall_i,
  output logic                    dec_valid_o,
  output mpu_pkg::core_req_t      dec_req_o,
  output pma_pkg::pma_cfg_t       dec_cfg_o
);
  import pma_pkg::*;

  word_addr_t  req_word;
  region_idx_t hit_idx;
  logic        hit;
  logic        dbg_match;
  pma_cfg_t    cfg;

  assign req_word = req_i.addr[`MPU_ADDR_W-1:2];

  //////////////////////////////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////////////////////////////

  // Scan from the top so the lowest matching index is left standing
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = `MPU_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((PMA_REGIONS[i].word_addr_low <= req_word) &&
          (req_word < PMA_REGIONS[i].word_addr_high)) begin
        hit     = 1'b1;
        hit_idx = region_idx_t'(i);
      end
    end
  end

  // Window end is inclusive
  assign dbg_match = req_i.debug &&
                     (req_i.addr >= `MPU_DM_START) &&
                     (req_i.addr <= `MPU_DM_END);

  always_comb begin
    if (dbg_match) begin
      cfg = PMA_DEBUG;
    end else if (hit) begin
      cfg = PMA_REGIONS[hit_idx];
    end else begin
      cfg = PMA_DEFAULT;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_o <= 1'b0;
    end else if (!stall_i) begin
      dec_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i && req_valid_i) begin
      dec_req_o <= req_i;
      dec_cfg_o <= cfg;
    end
  end

endmodule

`default_nettype wire

// File: tb/mpu_assert.sv
////////////////////////////////////////////////////////////////////////////
// MPU result stage assertions
// Credit bound and error response isolation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpu_assert (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire mpu_pkg::txn_cnt_t   credit_i,
  input  wire mpu_pkg::txn_cnt_t   outstanding_i,
  input  wire mpu_pkg::mpu_state_e state_i,
  input  wire logic                bus_req_valid_i,
  input  wire logic                bus_resp_valid_i
);
  import mpu_pkg::*;

  int unsigned fail_count = 0;

  // Credits only come back for requests that were issued
  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_i <= txn_cnt_t'(`MPU_BUS_CREDITS))
    else begin
      fail_count++;
      $error("credit count above the reset grant");
    end

  err_resp_drained: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == MPU_ERR_RESP) |-> (outstanding_i == '0))
    else begin
      fail_count++;
      $error("error response while bus transactions are open");
    end

  // Error response and bus-driven response never share a cycle
  err_resp_alone: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == MPU_ERR_RESP) |-> !bus_resp_valid_i)
    else begin
      fail_count++;
      $error("error response coincides with a bus response");
    end

endmodule

bind mpu_result mpu_assert u_assert (
  .clk              (clk),
  .rst_n            (rst_n),
  .credit_i         (credit_q),
  .outstanding_i    (outstanding_q),
  .state_i          (state_q),
  .bus_req_valid_i  (bus_req_valid_o),
  .bus_resp_valid_i (bus_resp_valid_i)
);

`default_nettype wire

// File: tb/mpu_checker.sv
////////////////////////////////////////////////////////////////////////////
// MPU reference model and scoreboard
// Predicts bus requests and core responses and compares them in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpu_checker (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                core_req_valid_i,
  input  wire logic                core_req_ready_i,
  input  wire mpu_pkg::core_req_t  core_req_i,
  input  wire logic                core_resp_valid_i,
  input  wire mpu_pkg::core_resp_t core_resp_i,
  input  wire logic                bus_req_valid_i,
  input  wire mpu_pkg::bus_req_t   bus_req_i,
  input  wire logic                bus_credit_i,
  input  wire logic                bus_resp_valid_i,
  input  wire logic                bus_resp_err_i,
  output int                       pending_o,
  output int                       error_count_o
);
  import mpu_pkg::*;

  // Byte bounds with exclusive high end
  localparam logic [31:0] REGION_LO [4] = '{32'h0000_0000, 32'h0000_0800,
                                            32'h1000_0000, 32'h0000_0000};
  localparam logic [31:0] REGION_HI [4] = '{32'h0000_1000, 32'h0001_0000,
                                            32'h1000_4000, 32'h2000_0000};
  // Attribute bits: main, bufferable, cacheable, atomic
  localparam logic [3:0]  REGION_ATTR [4] = '{4'b1011, 4'b1101, 4'b0100, 4'b1110};
  localparam logic [3:0]  ATTR_DEFAULT = 4'b1000;
  localparam logic [3:0]  ATTR_DEBUG   = 4'b1000;

  typedef struct packed {
    txn_id_t id;
    logic    refused;
  } resp_exp_t;

  bus_req_t  bus_exp_q [$];
  resp_exp_t resp_exp_q [$];
  logic      bus_err_q [$];
  int        credits_used = 0;
  int        open_bus = 0;
  int        errors = 0;
  logic      after_reset = 1'b0;

  function automatic logic [3:0] lookup_attr(input core_req_t r);
    logic [3:0] attr;
    logic       found;
    attr  = ATTR_DEFAULT;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!found && (r.addr >= REGION_LO[i]) && (r.addr < REGION_HI[i])) begin
        attr  = REGION_ATTR[i];
        found = 1'b1;
      end
    end
    if (r.debug && (r.addr >= 32'h1A11_0000) && (r.addr <= 32'h1A11_3FFF)) begin
      attr = ATTR_DEBUG;
    end
    return attr;
  endfunction

  task automatic flag_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
  endtask

  task automatic expect_request(input core_req_t r);
    logic [3:0] attr;
    logic       refused;
    bus_req_t   b;
    attr    = lookup_attr(r);
    refused = ((r.fetch || r.misaligned || r.pushpop) && !attr[3]) ||
              (r.atomic && (!attr[0] || r.misaligned));
    resp_exp_q.push_back('{id: r.id, refused: refused});
    if (!refused) begin
      b.addr       = r.addr;
      b.write      = r.write;
      b.bufferable = r.write && !r.atomic && attr[2];
      b.cacheable  = attr[1];
      b.id         = r.id;
      bus_exp_q.push_back(b);
    end
  endtask

  always @(posedge clk) begin : compare
    bus_req_t   exp_bus;
    resp_exp_t  exp_resp;
    core_resp_t want;
    if (rst_n) begin
      // Core port is open right after reset
      if (after_reset) begin
        after_reset = 1'b0;
        if (core_req_ready_i !== 1'b1) begin
          report_mismatch("core_req_ready_o", 64'(core_req_ready_i), 64'd1);
        end
      end
      if (core_req_valid_i && core_req_ready_i) begin
        expect_request(core_req_i);
      end
      // Bus requests of this same cycle are later than the response
      if (core_resp_valid_i) begin
        if (resp_exp_q.size() == 0) begin
          flag_failure("core response with no request waiting for one");
        end else begin
          exp_resp = resp_exp_q.pop_front();
          want.id  = exp_resp.id;
          want.err = 1'b1;
          if (exp_resp.refused) begin
            if (open_bus != 0) begin
              flag_failure($sformatf("error response with %0d bus requests open",
                                     open_bus));
            end
          end else if (bus_err_q.size() == 0) begin
            flag_failure("core response came before its bus response");
            want.err = 1'b0;
          end else begin
            want.err = bus_err_q.pop_front();
          end
          if (core_resp_i !== want) begin
            report_mismatch("core_resp_o", 64'(core_resp_i), 64'(want));
          end
        end
      end
      if (bus_req_valid_i) begin
        if (bus_exp_q.size() == 0) begin
          flag_failure("bus request issued with no allowed request waiting");
        end else begin
          exp_bus = bus_exp_q.pop_front();
          if (bus_req_i !== exp_bus) begin
            report_mismatch("bus_req_o", 64'(bus_req_i), 64'(exp_bus));
          end
        end
        open_bus++;
        credits_used++;
      end
      if (bus_credit_i) begin
        credits_used--;
      end
      if (credits_used > `MPU_BUS_CREDITS) begin
        flag_failure($sformatf("%0d bus requests open against the credit grant",
                               credits_used));
      end
      if (bus_resp_valid_i) begin
        bus_err_q.push_back(bus_resp_err_i);
        open_bus--;
      end
    end else begin
      after_reset = 1'b1;
    end
    pending_o     = resp_exp_q.size();
    error_count_o = errors;
  end

endmodule

`default_nettype wire

// File: tb/mpu_tb.sv
////////////////////////////////////////////////////////////////////////////
// MPU testbench
// Random core requests, in-order bus responder with credits, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mpu_defs.svh"

module mpu_tb #(
  parameter logic [31:0] SEED = 32'h98c3_33b7
);
  import mpu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_REQS   = 400;

  // Region edges first, then the debug window
  localparam logic [31:0] EDGES [12] = '{
    32'h0000_0000, 32'h0000_0800, 32'h0000_1000, 32'h0001_0000,
    32'h1000_0000, 32'h1000_4000, 32'h2000_0000, 32'h8000_0000,
    32'h1A11_0000, 32'h1A11_3FFC, 32'h1A11_4000, 32'h1A10_FFFC
  };

  typedef struct packed {
    txn_id_t     id;
    logic        err;
    logic [31:0] due;
  } resp_entry_t;

  logic       clk;
  logic       rst_n;
  logic       core_req_valid;
  logic       core_req_ready;
  core_req_t  core_req;
  logic       core_resp_valid;
  core_resp_t core_resp;
  logic       bus_req_valid;
  bus_req_t   bus_req;
  logic       bus_credit;
  logic       bus_resp_valid;
  logic       bus_resp_err;
  txn_id_t    bus_resp_id;
  int         pending;
  int         error_count;

  resp_entry_t resp_q [$];
  int unsigned cycle = 0;
  int unsigned issue_cnt = 0;
  logic [2:0]  resp_delay [1024];
  logic        resp_err [1024];

  mpu_top u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid),
    .core_req_ready_o  (core_req_ready),
    .core_req_i        (core_req),
    .core_resp_valid_o (core_resp_valid),
    .core_resp_o       (core_resp),
    .bus_req_valid_o   (bus_req_valid),
    .bus_req_o         (bus_req),
    .bus_credit_i      (bus_credit),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_resp_err_i    (bus_resp_err),
    .bus_resp_id_i     (bus_resp_id)
  );

  mpu_checker u_checker (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid),
    .core_req_ready_i  (core_req_ready),
    .core_req_i        (core_req),
    .core_resp_valid_i (core_resp_valid),
    .core_resp_i       (core_resp),
    .bus_req_valid_i   (bus_req_valid),
    .bus_req_i         (bus_req),
    .bus_credit_i      (bus_credit),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_resp_err_i    (bus_resp_err),
    .pending_o         (pending),
    .error_count_o     (error_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Bus responder, one response and one credit per request, in order
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : capture_issue
    resp_entry_t entry;
    if (rst_n && bus_req_valid) begin
      entry.id  = bus_req.id;
      entry.err = resp_err[issue_cnt % 1024];
      entry.due = cycle + 32'(resp_delay[issue_cnt % 1024]);
      if ((resp_q.size() > 0) && (entry.due <= resp_q[$].due)) begin
        entry.due = resp_q[$].due + 1;
      end
      resp_q.push_back(entry);
      issue_cnt++;
    end
    cycle++;
  end

  always @(negedge clk) begin : drive_resp
    bus_resp_valid = 1'b0;
    bus_credit     = 1'b0;
    bus_resp_err   = 1'b0;
    bus_resp_id    = '0;
    if ((resp_q.size() > 0) && (resp_q[0].due <= cycle)) begin
      bus_resp_valid = 1'b1;
      bus_credit     = 1'b1;
      bus_resp_err   = resp_q[0].err;
      bus_resp_id    = resp_q[0].id;
      void'(resp_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic int error_total();
    return error_count + int'(u_dut.u_result.u_assert.fail_count);
  endfunction

  // Mode 0 region edges, 1 debug window, 2 error heavy, others anything
  function automatic core_req_t random_request(input int mode);
    core_req_t   r;
    int unsigned pick;
    int unsigned odds;
    case (mode)
      0:       pick = $urandom_range(7);
      1:       pick = 8 + $urandom_range(3);
      default: pick = $urandom_range(11);
    endcase
    odds = (mode == 2) ? 2 : 7;
    r.addr       = EDGES[pick] + 32'($urandom_range(15)) - 32'd8;
    r.write      = 1'($urandom_range(1));
    r.fetch      = ($urandom_range(odds) == 0);
    r.misaligned = ($urandom_range(odds) == 0);
    r.atomic     = ($urandom_range(odds) == 0);
    r.pushpop    = ($urandom_range(odds) == 0);
    r.debug      = (mode == 1) ? 1'($urandom_range(1)) : ($urandom_range(3) == 0);
    r.id         = 4'($urandom_range(15));
    return r;
  endfunction

  task automatic run_phase(input string name, input int count, input int mode);
    int   sent;
    int   err_before;
    logic took;
    logic ready_seen;
    sent       = 0;
    ready_seen = 1'b0;
    err_before = error_total();
    while (sent < count) begin
      @(negedge clk);
      // Ready only depends on registers, so the value seen here held at the edge
      took = core_req_valid && ready_seen;
      if (took) begin
        sent++;
      end
      if (took || !core_req_valid) begin
        if ((sent < count) && ((mode == 3) || ($urandom_range(3) != 0))) begin
          core_req       = random_request(mode);
          core_req_valid = 1'b1;
        end else begin
          core_req_valid = 1'b0;
        end
      end
      ready_seen = core_req_ready;
    end
    wait (pending == 0);
    @(negedge clk);
    $display("Test %s: %0d requests, %0d errors", name, count, error_total() - err_before);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    bus_credit     = 1'b0;
    bus_resp_valid = 1'b0;
    bus_resp_err   = 1'b0;
    bus_resp_id    = '0;
    void'($urandom(SEED));
    for (int i = 0; i < 1024; i++) begin
      resp_delay[i] = 3'(1 + $urandom_range(5));
      resp_err[i]   = ($urandom_range(7) == 0);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_phase("region_edges", 120, 0);
    run_phase("debug_window", 80, 1);
    run_phase("error_mix", 100, 2);
    run_phase("back_to_back", 100, 3);
    $display("Summary: 4 tests, %0d requests, %0d errors", NUM_REQS, error_total());
    if (error_total() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Generous bound of 20 cycles per request
  initial begin : watchdog
    #(NUM_REQS * 20 * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d ns", NUM_REQS * 20 * CLK_PERIOD);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
